// ==== hw/soc_cfg_pkg.sv ====
// Bus widths, memory depths and debug delay shared by every stage of the memory harness
`default_nettype none

package soc_cfg_pkg;

  // --------------------
  // Bus geometry
  // --------------------
  localparam int unsigned addr_width    = 32;
  localparam int unsigned data_width    = 64;
  localparam int unsigned be_width      = data_width / 8;
  localparam int unsigned byte_off_bits = $clog2(be_width);

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [be_width-1:0]   be_t;

  // --------------------
  // Memories
  // --------------------
  localparam int unsigned sram_words    = 256;
  localparam int unsigned rom_words     = 32;
  localparam int unsigned sram_idx_bits = $clog2(sram_words);
  localparam int unsigned rom_idx_bits  = $clog2(rom_words);
  localparam int unsigned exit_width    = 32;

  // Boot window before a debugger may halt the core
  localparam int unsigned debug_delay_cycles = 16;
  localparam int unsigned debug_cnt_bits     = $clog2(debug_delay_cycles + 1);

  typedef logic [debug_cnt_bits-1:0] debug_cnt_t;

endpackage

`default_nettype wire

// ==== hw/soc_map_pkg.sv ====
// Address map of the harness and the boot ROM contents, used by the decoder and the memory bank
`default_nettype none

package soc_map_pkg;

  // Target of a decoded request
  typedef enum logic [1:0] {
    REG_ROM,
    REG_SRAM,
    REG_EXIT,
    REG_NONE
  } region_e;

  // --------------------
  // Address map
  // --------------------
  localparam soc_cfg_pkg::addr_t rom_base    = 32'h0001_0000;
  localparam soc_cfg_pkg::addr_t rom_length  = 32'h0000_0100;

  localparam soc_cfg_pkg::addr_t exit_base   = 32'h0002_0000;
  localparam soc_cfg_pkg::addr_t exit_length = 32'h0000_0008;

  localparam soc_cfg_pkg::addr_t sram_base   = 32'h8000_0000;
  localparam soc_cfg_pkg::addr_t sram_length = 32'h0000_0800;

  // --------------------
  // Boot ROM
  // --------------------

  // Tag in the upper half, word index in the lower half
  function automatic soc_cfg_pkg::data_t rom_word(input int unsigned i);
    soc_cfg_pkg::data_t word;
    word = {32'hB007_B007, i[31:0]};
    return word;
  endfunction

endpackage

`default_nettype wire

// ==== hw/mem_bus_if.sv ====
// Decoded request bus from the address decoder to the memory bank and result stage
`default_nettype none
`timescale 1ns/1ps

interface mem_bus_if;

  logic                   req;
  logic                   we;
  soc_cfg_pkg::addr_t     addr;
  soc_cfg_pkg::be_t       be;
  soc_cfg_pkg::data_t     wdata;
  soc_map_pkg::region_e   region;

  // Driven by the decode stage
  modport decoder (
    output req,
    output we,
    output addr,
    output be,
    output wdata,
    output region
  );

  // Seen by the execute and result stages
  modport bank (
    input req,
    input we,
    input addr,
    input be,
    input wdata,
    input region
  );

endinterface

`default_nettype wire

// ==== hw/addr_decode.sv ====
// Decode stage that tags each incoming request with its address map region
`default_nettype none
`timescale 1ns/1ps

module addr_decode (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  soc_cfg_pkg::addr_t addr_i,
  input  soc_cfg_pkg::be_t   be_i,
  input  soc_cfg_pkg::data_t wdata_i,
  mem_bus_if.decoder         bus
);

  // Half-open range check, base inclusive
  function automatic logic in_range(
    input soc_cfg_pkg::addr_t addr,
    input soc_cfg_pkg::addr_t base,
    input soc_cfg_pkg::addr_t length
  );
    return (addr >= base) && (addr < base + length);
  endfunction

  always_comb begin
    bus.region = soc_map_pkg::REG_NONE;
    if (in_range(addr_i, soc_map_pkg::rom_base, soc_map_pkg::rom_length)) begin
      bus.region = soc_map_pkg::REG_ROM;
    end else if (in_range(addr_i, soc_map_pkg::sram_base, soc_map_pkg::sram_length)) begin
      bus.region = soc_map_pkg::REG_SRAM;
    end else if (in_range(addr_i, soc_map_pkg::exit_base, soc_map_pkg::exit_length)) begin
      bus.region = soc_map_pkg::REG_EXIT;
    end
  end

  assign bus.req   = req_i;
  assign bus.we    = we_i;
  assign bus.addr  = addr_i;
  assign bus.be    = be_i;
  assign bus.wdata = wdata_i;

  // Strobe must be clean once out of reset, every later stage keys off it
  a_req_known: assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(req_i))
    else $error("Request strobe is unknown after reset");

endmodule

`default_nettype wire

// ==== hw/region_access.sv ====
// Execute stage with the SRAM, the boot ROM output register and the exit word
`default_nettype none
`timescale 1ns/1ps

module region_access (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  mem_bus_if.bank                              bus,
  output soc_cfg_pkg::data_t                   rom_rdata_o,
  output soc_cfg_pkg::data_t                   sram_rdata_o,
  output logic [soc_cfg_pkg::exit_width-1:0]   exit_o
);

  soc_cfg_pkg::data_t                      sram_q [soc_cfg_pkg::sram_words];
  logic [soc_cfg_pkg::sram_idx_bits-1:0]   sram_idx;
  logic [soc_cfg_pkg::rom_idx_bits-1:0]    rom_idx;
  logic                                    sram_sel;
  logic                                    rom_sel;
  logic                                    exit_wr;

  // Word index sits just above the byte offset
  assign sram_idx = bus.addr[soc_cfg_pkg::byte_off_bits +: soc_cfg_pkg::sram_idx_bits];
  assign rom_idx  = bus.addr[soc_cfg_pkg::byte_off_bits +: soc_cfg_pkg::rom_idx_bits];

  assign sram_sel = bus.req && (bus.region == soc_map_pkg::REG_SRAM);
  assign rom_sel  = bus.req && !bus.we && (bus.region == soc_map_pkg::REG_ROM);

  // Exit word only takes a full lower 32-bit write
  assign exit_wr  = bus.req && bus.we && (bus.region == soc_map_pkg::REG_EXIT) &&
                    (&bus.be[3:0]);

  // --------------------
  // SRAM
  // --------------------
  always_ff @(posedge clk_i) begin
    if (sram_sel) begin
      if (bus.we) begin
        for (int b = 0; b < soc_cfg_pkg::be_width; b++) begin
          if (bus.be[b]) begin
            sram_q[sram_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
          end
        end
      end else begin
        sram_rdata_o <= sram_q[sram_idx];
      end
    end
  end

  // --------------------
  // Boot ROM
  // --------------------
  // Writes to the ROM fall through here and change nothing
  always_ff @(posedge clk_i) begin
    if (rom_sel) begin
      rom_rdata_o <= soc_map_pkg::rom_word(rom_idx);
    end
  end

  // --------------------
  // Exit word
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_o <= '0;
    end else if (exit_wr) begin
      exit_o <= bus.wdata[soc_cfg_pkg::exit_width-1:0];
    end
  end

  // A write with no byte lanes would still raise a response but store nothing
  a_write_be: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.req && bus.we |-> bus.be != '0)
    else $error("Write request without byte enables");

endmodule

`default_nettype wire

// ==== hw/resp_select.sv ====
// Result stage that turns the registered request into rvalid, read data and error
`default_nettype none
`timescale 1ns/1ps

module resp_select (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  mem_bus_if.bank                              bus,
  input  soc_cfg_pkg::data_t                   rom_rdata_i,
  input  soc_cfg_pkg::data_t                   sram_rdata_i,
  input  logic [soc_cfg_pkg::exit_width-1:0]   exit_i,
  output logic                                 rvalid_o,
  output soc_cfg_pkg::data_t                   rdata_o,
  output logic                                 err_o
);

  logic                   valid_q;
  logic                   we_q;
  soc_map_pkg::region_e   region_q;

  // Aligned with the execute stage registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      region_q <= soc_map_pkg::REG_NONE;
    end else begin
      valid_q  <= bus.req;
      we_q     <= bus.we;
      region_q <= bus.region;
    end
  end

  // Writes always answer with zero data
  always_comb begin
    rdata_o = '0;
    if (valid_q && !we_q) begin
      case (region_q)
        soc_map_pkg::REG_SRAM: rdata_o = sram_rdata_i;
        soc_map_pkg::REG_ROM:  rdata_o = rom_rdata_i;
        soc_map_pkg::REG_EXIT: rdata_o = soc_cfg_pkg::data_t'(exit_i);
        default:               rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = valid_q;
  assign err_o    = valid_q && (region_q == soc_map_pkg::REG_NONE);

  // An error is a response of its own and carries no data
  a_err_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_o |-> rvalid_o && (rdata_o == '0))
    else $error("Error response without rvalid or with nonzero data");

endmodule

`default_nettype wire

// ==== hw/debug_req_gate.sv ====
// Holds off debug requests for a fixed window after reset and when debug is disabled
`default_nettype none
`timescale 1ns/1ps

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  soc_cfg_pkg::debug_cnt_t cnt_q;

  // Gives boot code time to run before a halt can land
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= soc_cfg_pkg::debug_cnt_t'(soc_cfg_pkg::debug_delay_cycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) && debug_enable_i && debug_req_i;

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= soc_cfg_pkg::debug_delay_cycles)
    else $error("Debug delay counter above its reset value");

endmodule

`default_nettype wire

// ==== hw/soc_harness.sv ====
// Top level of the memory harness, connecting decode, execute and result stages and the debug gate
`default_nettype none
`timescale 1ns/1ps

module soc_harness (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [7:0]  be_i,
  input  logic [63:0] wdata_i,
  output logic        rvalid_o,
  output logic [63:0] rdata_o,
  output logic        err_o,
  input  logic        debug_req_i,
  input  logic        debug_enable_i,
  output logic        debug_req_o,
  output logic [31:0] exit_o
);

  soc_cfg_pkg::data_t rom_rdata;
  soc_cfg_pkg::data_t sram_rdata;

  mem_bus_if bus ();

  // --------------------
  // Memory path
  // --------------------
  addr_decode i_addr_decode (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .req_i   ( req_i   ),
    .we_i    ( we_i    ),
    .addr_i  ( addr_i  ),
    .be_i    ( be_i    ),
    .wdata_i ( wdata_i ),
    .bus     ( bus     )
  );

  region_access i_region_access (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .bus          ( bus        ),
    .rom_rdata_o  ( rom_rdata  ),
    .sram_rdata_o ( sram_rdata ),
    .exit_o       ( exit_o     )
  );

  resp_select i_resp_select (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .bus          ( bus        ),
    .rom_rdata_i  ( rom_rdata  ),
    .sram_rdata_i ( sram_rdata ),
    .exit_i       ( exit_o     ),
    .rvalid_o     ( rvalid_o   ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      )
  );

  // --------------------
  // Debug
  // --------------------
  debug_req_gate i_debug_req_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

`default_nettype wire

// ==== sim/tb_soc_harness.sv ====
// Table-driven testbench for the memory harness, compiled with the file list as top module
`default_nettype none
`timescale 1ns/1ps

module tb_soc_harness;

  typedef struct packed {
    logic        dbg;
    logic        we;
    logic [31:0] addr;
    logic [7:0]  be;
    logic [63:0] wdata;
    logic [63:0] exp_rdata;
    logic        exp_err;
    logic [31:0] exp_exit;
  } entry_t;

  localparam logic [63:0] word_a = 64'h1122_3344_5566_7788;
  localparam logic [63:0] word_b = 64'hDEAD_BEEF_CAFE_F00D;
  localparam logic [63:0] word_c = 64'h0F1E_2D3C_4B5A_6978;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        req_i;
  logic        we_i;
  logic [31:0] addr_i;
  logic [7:0]  be_i;
  logic [63:0] wdata_i;
  logic        rvalid_o;
  logic [63:0] rdata_o;
  logic        err_o;
  logic        debug_req_i;
  logic        debug_enable_i;
  logic        debug_req_o;
  logic [31:0] exit_o;
  entry_t      table_q [$];

  soc_harness soc_harness_i (.*);

  always #5 clk_i = ~clk_i;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on failure");
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      fail_run("Stopping at the first mismatch");
    end
  endtask

  // Byte lanes with be set take the new data
  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                              input logic [63:0] new_word,
                                              input logic [7:0]  be);
    logic [63:0] merged;
    merged = old_word;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) merged[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return merged;
  endfunction

  function automatic logic [31:0] rom_addr(input int unsigned idx);
    return soc_map_pkg::rom_base + 32'(idx * 8);
  endfunction

  task automatic add_entry(input logic dbg, input logic we, input logic [31:0] addr,
                           input logic [7:0] be, input logic [63:0] wdata,
                           input logic [63:0] exp_rdata, input logic exp_err,
                           input logic [31:0] exp_exit);
    table_q.push_back(entry_t'{dbg, we, addr, be, wdata, exp_rdata, exp_err, exp_exit});
  endtask

  // --------------------
  // Stimulus table
  // --------------------
  task automatic build_table();
    logic [31:0] w3;
    logic [31:0] w4;
    logic [31:0] beyond;
    logic [63:0] merged;
    w3     = soc_map_pkg::sram_base + 32'h18;
    w4     = soc_map_pkg::sram_base + 32'h20;
    beyond = soc_map_pkg::sram_base + soc_map_pkg::sram_length;
    merged = merge_bytes(word_a, word_b, 8'h0F);
    add_entry(1'b0, 1'b1, w3, 8'hFF, word_a, '0, 1'b0, 32'd0);
    add_entry(1'b0, 1'b1, w3, 8'h0F, word_b, '0, 1'b0, 32'd0);
    add_entry(1'b0, 1'b0, w3, 8'hFF, '0, merged, 1'b0, 32'd0);
    add_entry(1'b0, 1'b0, rom_addr(0), 8'hFF, '0, soc_map_pkg::rom_word(0), 1'b0, 32'd0);
    add_entry(1'b0, 1'b0, rom_addr(5), 8'hFF, '0, soc_map_pkg::rom_word(5), 1'b0, 32'd0);
    add_entry(1'b0, 1'b0, rom_addr(31), 8'hFF, '0, soc_map_pkg::rom_word(31), 1'b0, 32'd0);
    add_entry(1'b0, 1'b1, rom_addr(5), 8'hFF, '1, '0, 1'b0, 32'd0);
    add_entry(1'b0, 1'b0, rom_addr(5), 8'hFF, '0, soc_map_pkg::rom_word(5), 1'b0, 32'd0);
    add_entry(1'b0, 1'b0, 32'h0, 8'hFF, '0, '0, 1'b1, 32'd0);
    add_entry(1'b0, 1'b1, 32'h0, 8'hFF, word_a, '0, 1'b1, 32'd0);
    add_entry(1'b0, 1'b0, beyond, 8'hFF, '0, '0, 1'b1, 32'd0);
    add_entry(1'b0, 1'b1, beyond, 8'hFF, word_c, '0, 1'b1, 32'd0);
    // Exit word is visible together with the write response
    add_entry(1'b0, 1'b1, soc_map_pkg::exit_base, 8'h0F, 64'h1, '0, 1'b0, 32'd1);
    add_entry(1'b0, 1'b0, soc_map_pkg::exit_base, 8'hFF, '0, 64'h1, 1'b0, 32'd1);
    add_entry(1'b0, 1'b1, w4, 8'hFF, word_c, '0, 1'b0, 32'd1);
    add_entry(1'b1, 1'b0, w4, 8'hFF, '0, word_c, 1'b0, 32'd1);
    add_entry(1'b1, 1'b0, w3, 8'hFF, '0, merged, 1'b0, 32'd1);
  endtask

  task automatic apply_entry(input entry_t e);
    req_i          = 1'b1;
    we_i           = e.we;
    addr_i         = e.addr;
    be_i           = e.be;
    wdata_i        = e.wdata;
    debug_req_i    = e.dbg;
    debug_enable_i = 1'b1;
  endtask

  task automatic idle_bus();
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    be_i        = '0;
    wdata_i     = '0;
    debug_req_i = 1'b0;
  endtask

  task automatic check_response(input entry_t e, input int idx);
    if (!rvalid_o) begin
      fail_run($sformatf("No response for table entry %0d one cycle after its request", idx));
    end
    check_value(rdata_o, e.exp_rdata, $sformatf("rdata_o of entry %0d", idx));
    check_value(err_o, e.exp_err, $sformatf("err_o of entry %0d", idx));
    check_value(exit_o, e.exp_exit, $sformatf("exit_o of entry %0d", idx));
  endtask

  initial begin
    #1;
    #((10 + table_q.size() * 2 + 40) * 10);
    fail_run("Watchdog expired before the test sequence finished");
  end

  initial begin
    build_table();
    rst_ni         = 1'b0;
    debug_req_i    = 1'b1;
    debug_enable_i = 1'b1;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // Debug window, cycle 1 starts at reset release
    for (int k = 1; k <= 17; k++) begin
      #4;
      check_value(debug_req_o, k == 17, $sformatf("debug_req_o in cycle %0d", k));
      @(posedge clk_i);
      #1;
    end
    debug_enable_i = 1'b0;
    #4;
    check_value(debug_req_o, 1'b0, "debug_req_o with debug disabled");

    // One request per cycle, each response checked in the following cycle
    for (int i = 0; i <= table_q.size(); i++) begin
      @(posedge clk_i);
      #1;
      if (i < table_q.size()) apply_entry(table_q[i]);
      else idle_bus();
      #4;
      if (i < table_q.size()) begin
        check_value(debug_req_o, table_q[i].dbg, $sformatf("debug_req_o of entry %0d", i));
      end
      if (i > 0) check_response(table_q[i-1], i - 1);
    end
    @(posedge clk_i);
    #5;
    check_value(rvalid_o, 1'b0, "rvalid_o after the bus went idle");

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== soc_harness.f ====
hw/soc_cfg_pkg.sv
hw/soc_map_pkg.sv
hw/mem_bus_if.sv
hw/addr_decode.sv
hw/region_access.sv
hw/resp_select.sv
hw/debug_req_gate.sv
hw/soc_harness.sv
sim/tb_soc_harness.sv

// ==== Bender.yml ====
package:
  name: soc_harness

sources:
  - hw/soc_cfg_pkg.sv
  - hw/soc_map_pkg.sv
  - hw/mem_bus_if.sv
  - hw/addr_decode.sv
  - hw/region_access.sv
  - hw/resp_select.sv
  - hw/debug_req_gate.sv
  - hw/soc_harness.sv
  - target: simulation
    files:
      - sim/tb_soc_harness.sv
